// File: Makefile
TOP := edge_buffer_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/edge_buffer_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "edge_settings.svh"

module edge_buffer_tb;

    logic                                   clk = 1'b0;
    logic                                   reset = 1'b0;
    edge_pkg::edge_pkt_t [`NUM_EDGE_PE-1:0] edge_pkt = '0;
    logic                                   busy;
    logic                                   rs_req;
    logic                                   rs_ack = 1'b0;
    edge_pkg::rs_pkt_t                      rs_pkt;
    logic                [`NUM_EDGE_PE-1:0] sram_req;
    logic                [`NUM_EDGE_PE-1:0] sram_ack = '0;
    edge_pkg::sram_req_t [`NUM_EDGE_PE-1:0] sram_pkt;

    integer seed = 32'h983e2e1f;
    int     value_errors = 0;
    int     other_errors = 0;
    string  test_name = "startup";
    // responder controls
    logic   rs_hold = 1'b0;
    logic   rand_delay = 1'b0;
    int     rs_wait = 0;
    int     rs_delay = 0;
    int     sram_wait [`NUM_EDGE_PE] = '{default: 0};
    int     sram_delay [`NUM_EDGE_PE] = '{default: 0};
    // expected traffic per lane, in push order
    edge_pkg::rs_pkt_t   rs_exp [`NUM_EDGE_PE][$];
    edge_pkg::sram_req_t sram_exp [`NUM_EDGE_PE][$];
    logic [`LANE_W-1:0]  rs_order [$];
    // lane with top priority at the next pick
    logic [`LANE_W-1:0]  rr_next = '0;

    edge_buffer_top DUT (
        .clk      (clk),
        .reset    (reset),
        .edge_pkt (edge_pkt),
        .busy     (busy),
        .rs_req   (rs_req),
        .rs_ack   (rs_ack),
        .rs_pkt   (rs_pkt),
        .sram_req (sram_req),
        .sram_ack (sram_ack),
        .sram_pkt (sram_pkt)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic edge_pkg::edge_pkt_t make_pkt(input logic wb);
        edge_pkg::edge_pkt_t p;
        logic [31:0]         rnd;
        rnd = $random(seed);
        p.valid = 1'b1;
        p.sos = rnd[0];
        p.eos = rnd[1];
        p.done_aggr = rnd[2];
        p.wb_en = wb;
        rnd = $random(seed);
        p.fv_data[0] = rnd[`FV_SIZE-1:0];
        rnd = $random(seed);
        p.fv_data[1] = rnd[`FV_SIZE-1:0];
        return p;
    endfunction

    function automatic edge_pkg::rs_pkt_t rs_view(input edge_pkg::edge_pkt_t p, input int lane);
        edge_pkg::rs_pkt_t r;
        r.lane = lane[`LANE_W-1:0];
        r.sos = p.sos;
        r.eos = p.eos;
        r.fv_data = p.fv_data;
        r.done_aggr = p.done_aggr;
        return r;
    endfunction

    function automatic edge_pkg::sram_req_t sram_view(input edge_pkg::edge_pkt_t p);
        edge_pkg::sram_req_t s;
        s.sos = p.sos;
        s.eos = p.eos;
        s.fv_data = p.fv_data;
        return s;
    endfunction

    function automatic int pick_delay();
        logic [31:0] rnd;
        if (!rand_delay)
            return 0;
        rnd = $random(seed);
        return {30'd0, rnd[1:0]};
    endfunction

    task automatic compare_rs(input string name, input edge_pkg::rs_pkt_t want,
                              input edge_pkg::rs_pkt_t got);
        if (got !== want) begin
            $display("** Error %s: rs_pkt expected %h, actual %h", name, want, got);
            value_errors++;
        end
    endtask

    task automatic compare_sram(input string name, input edge_pkg::sram_req_t want,
                                input edge_pkg::sram_req_t got);
        if (got !== want) begin
            $display("** Error %s: sram_pkt expected %h, actual %h", name, want, got);
            value_errors++;
        end
    endtask

    task automatic compare_lane(input string name, input logic [`LANE_W-1:0] want,
                                input logic [`LANE_W-1:0] got);
        if (got !== want) begin
            $display("** Error %s: lane expected %0d, actual %0d", name, want, got);
            value_errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic want, input logic got);
        if (got !== want) begin
            $display("** Error %s: flag expected %b, actual %b", name, want, got);
            value_errors++;
        end
    endtask

    task automatic report_timeout(input string why);
        $display("%s: %s", test_name, why);
        other_errors++;
    endtask

    // four-phase RS and SRAM responders with a delay before ack
    always @(negedge clk) begin
        if (reset) begin
            if (rs_ack) begin
                if (!rs_req)
                    rs_ack <= 1'b0;
            end else if (rs_req && !rs_hold) begin
                if (rs_wait < rs_delay) begin
                    rs_wait++;
                end else begin
                    if (rs_exp[rs_pkt.lane].size() == 0) begin
                        $display("%s: unexpected RS packet from lane %0d", test_name, rs_pkt.lane);
                        other_errors++;
                    end else begin
                        compare_rs(test_name, rs_exp[rs_pkt.lane].pop_front(), rs_pkt);
                    end
                    rs_order.push_back(rs_pkt.lane);
                    rs_ack <= 1'b1;
                    rs_wait = 0;
                    rs_delay = pick_delay();
                end
            end
            for (int i = 0; i < `NUM_EDGE_PE; i++) begin
                if (sram_ack[i]) begin
                    if (!sram_req[i])
                        sram_ack[i] <= 1'b0;
                end else if (sram_req[i]) begin
                    if (sram_wait[i] < sram_delay[i]) begin
                        sram_wait[i]++;
                    end else begin
                        if (sram_exp[i].size() == 0) begin
                            $display("%s: unexpected write-back on lane %0d", test_name, i);
                            other_errors++;
                        end else begin
                            compare_sram(test_name, sram_exp[i].pop_front(), sram_pkt[i]);
                        end
                        sram_ack[i] <= 1'b1;
                        sram_wait[i] = 0;
                        sram_delay[i] = pick_delay();
                    end
                end
            end
        end
    end

    // one push cycle on all lanes once busy is low
    task automatic send_lanes(input edge_pkg::edge_pkt_t [`NUM_EDGE_PE-1:0] pkts);
        int waited;
        waited = 0;
        while (busy && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (busy)
            report_timeout("timed out waiting for busy to drop");
        edge_pkt = pkts;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (pkts[i].valid && pkts[i].wb_en)
                sram_exp[i].push_back(sram_view(pkts[i]));
            else if (pkts[i].valid)
                rs_exp[i].push_back(rs_view(pkts[i], i));
        end
        @(negedge clk);
        edge_pkt = '0;
    endtask

    function automatic logic drained();
        logic done;
        done = !rs_req && !rs_ack && sram_req == '0 && sram_ack == '0 && !busy;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (rs_exp[i].size() != 0 || sram_exp[i].size() != 0)
                done = 1'b0;
        end
        return done;
    endfunction

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (!drained() && waited < 2000) begin
            @(negedge clk);
            waited++;
        end
        if (!drained())
            report_timeout("timed out waiting for RS and SRAM traffic to drain");
    endtask

    task automatic check_reset_state();
        test_name = "reset_state";
        compare_flag(test_name, 1'b0, rs_req);
        compare_flag(test_name, 1'b0, busy);
        compare_flag(test_name, 1'b0, |sram_req);
    endtask

    task automatic single_rs_packet();
        edge_pkg::edge_pkt_t [`NUM_EDGE_PE-1:0] pkts;
        test_name = "single_rs_packet";
        pkts = '0;
        pkts[2] = make_pkt(1'b0);
        send_lanes(pkts);
        wait_drain();
        // lane 3 follows the lane 2 winner
        rr_next = 2'd3;
    endtask

    task automatic write_back_routing();
        edge_pkg::edge_pkt_t [`NUM_EDGE_PE-1:0] pkts;
        test_name = "write_back_routing";
        pkts = '0;
        pkts[1] = make_pkt(1'b1);
        send_lanes(pkts);
        wait_drain();
    endtask

    // every lane pushed at once and served in rotation from rr_next
    task automatic round_robin_order();
        edge_pkg::edge_pkt_t [`NUM_EDGE_PE-1:0] pkts;
        logic [`LANE_W-1:0]                     want_lane;
        test_name = "round_robin_order";
        for (int round = 0; round < 2; round++) begin
            rs_order = {};
            want_lane = rr_next;
            for (int i = 0; i < `NUM_EDGE_PE; i++)
                pkts[i] = make_pkt(1'b0);
            send_lanes(pkts);
            wait_drain();
            if (rs_order.size() != `NUM_EDGE_PE) begin
                $display("%s: saw %0d RS transfers in a round", test_name, rs_order.size());
                other_errors++;
            end else begin
                for (int k = 0; k < `NUM_EDGE_PE; k++) begin
                    compare_lane(test_name, want_lane, rs_order[k]);
                    want_lane++;
                end
            end
        end
    endtask

    task automatic back_pressure();
        edge_pkg::edge_pkt_t [`NUM_EDGE_PE-1:0] pkts;
        test_name = "back_pressure";
        rs_hold = 1'b1;
        pkts = '0;
        for (int n = 0; n < `LANE_DEPTH; n++) begin
            pkts[3] = make_pkt(1'b0);
            send_lanes(pkts);
            compare_flag(test_name, n == `LANE_DEPTH - 1, busy);
        end
        compare_flag(test_name, 1'b1, rs_req);
        rs_hold = 1'b0;
        pkts[3] = make_pkt(1'b0);
        send_lanes(pkts);
        wait_drain();
    endtask

    task automatic mixed_traffic();
        edge_pkg::edge_pkt_t [`NUM_EDGE_PE-1:0] pkts;
        logic [31:0]                            rnd;
        test_name = "mixed_traffic";
        rand_delay = 1'b1;
        for (int b = 0; b < 16; b++) begin
            rnd = $random(seed);
            for (int i = 0; i < `NUM_EDGE_PE; i++) begin
                pkts[i] = '0;
                if (rnd[i])
                    pkts[i] = make_pkt(rnd[i + 4]);
            end
            send_lanes(pkts);
        end
        wait_drain();
        rand_delay = 1'b0;
    endtask

    initial begin
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        check_reset_state();
        single_rs_packet();
        write_back_routing();
        round_robin_order();
        back_pressure();
        mixed_traffic();
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/edge_pkg.sv
logic/edge_lane_fifo.sv
logic/rs_arbiter.sv
logic/sram_wb_port.sv
logic/edge_bank_ctrl.sv
logic/edge_buffer_top.sv
bench/edge_buffer_tb.sv

// File: logic/edge_bank_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "edge_settings.svh"

module edge_bank_ctrl (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                [`NUM_EDGE_PE-1:0]     grant,
    input  edge_pkg::edge_pkt_t [`NUM_EDGE_PE-1:0]     heads,
    input  logic                                       rs_ack,
    output logic                                       arb_enable,
    output logic                                       rs_req,
    output edge_pkg::rs_pkt_t                          rs_pkt,
    output logic                [`NUM_EDGE_PE-1:0]     rs_pop
);

    edge_pkg::rs_state_e     state;
    edge_pkg::rs_state_e     state_next;
    // lane being served, one-hot
    logic [`NUM_EDGE_PE-1:0] lane_sel;
    edge_pkg::edge_pkt_t     grant_head;
    logic [`LANE_W-1:0]      grant_lane;

    // one-hot grant to head and lane number
    always_comb begin
        grant_head = '0;
        grant_lane = '0;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (grant[i]) begin
                grant_head = heads[i];
                grant_lane = i[`LANE_W-1:0];
            end
        end
    end

    // idle gives the arbiter one enable cycle, its registered grant
    // shows up in grant_wait, so the pointer moves only once per pick
    always_comb begin
        state_next = state;
        case (state)
            edge_pkg::idle: begin
                state_next = edge_pkg::grant_wait;
            end
            edge_pkg::grant_wait: begin
                if (|grant)
                    state_next = edge_pkg::req_high;
                else
                    state_next = edge_pkg::idle;
            end
            edge_pkg::req_high: begin
                if (rs_ack)
                    state_next = edge_pkg::ack_low;
            end
            edge_pkg::ack_low: begin
                if (!rs_ack)
                    state_next = edge_pkg::idle;
            end
            default: state_next = edge_pkg::idle;
        endcase
    end

    assign arb_enable = (state == edge_pkg::idle);
    assign rs_req     = (state == edge_pkg::req_high);
    // pop as soon as RS has taken the packet
    assign rs_pop = (state == edge_pkg::req_high && rs_ack) ? lane_sel : '0;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= edge_pkg::idle;
            lane_sel <= '0;
        end else begin
            state <= state_next;
            if (state == edge_pkg::grant_wait)
                lane_sel <= grant;
        end
    end

    always_ff @(posedge clk) begin
        if (state == edge_pkg::grant_wait && |grant) begin
            rs_pkt.lane      <= grant_lane;
            rs_pkt.sos       <= grant_head.sos;
            rs_pkt.eos       <= grant_head.eos;
            rs_pkt.fv_data   <= grant_head.fv_data;
            rs_pkt.done_aggr <= grant_head.done_aggr;
        end
    end

endmodule

`default_nettype wire

// File: logic/edge_buffer_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "edge_settings.svh"

module edge_buffer_top (
    input  logic                                   clk,
    input  logic                                   reset,
    input  edge_pkg::edge_pkt_t [`NUM_EDGE_PE-1:0] edge_pkt,
    output logic                                   busy,
    output logic                                   rs_req,
    input  logic                                   rs_ack,
    output edge_pkg::rs_pkt_t                      rs_pkt,
    output logic                [`NUM_EDGE_PE-1:0] sram_req,
    input  logic                [`NUM_EDGE_PE-1:0] sram_ack,
    output edge_pkg::sram_req_t [`NUM_EDGE_PE-1:0] sram_pkt
);

    edge_pkg::edge_pkt_t [`NUM_EDGE_PE-1:0] heads;
    logic [`NUM_EDGE_PE-1:0] head_valid;
    logic [`NUM_EDGE_PE-1:0] full;
    logic [`NUM_EDGE_PE-1:0] wb_pop;
    logic [`NUM_EDGE_PE-1:0] rs_pop;
    logic [`NUM_EDGE_PE-1:0] lane_pop;
    logic [`NUM_EDGE_PE-1:0] arb_req;
    logic [`NUM_EDGE_PE-1:0] grant;
    logic                    arb_enable;

    assign busy = |full;

    for (genvar i = 0; i < `NUM_EDGE_PE; i++) begin : g_lane
        // wb_en at the head picks the path, so the two pops never collide
        assign arb_req[i]  = head_valid[i] && !heads[i].wb_en;
        assign lane_pop[i] = wb_pop[i] | rs_pop[i];

        edge_lane_fifo u_fifo (
            .clk        (clk),
            .reset      (reset),
            .push_pkt   (edge_pkt[i]),
            .pop        (lane_pop[i]),
            .head       (heads[i]),
            .head_valid (head_valid[i]),
            .full       (full[i])
        );

        sram_wb_port u_wb (
            .clk        (clk),
            .reset      (reset),
            .head       (heads[i]),
            .head_valid (head_valid[i]),
            .sram_ack   (sram_ack[i]),
            .sram_req   (sram_req[i]),
            .sram_pkt   (sram_pkt[i]),
            .pop        (wb_pop[i])
        );
    end

    rs_arbiter u_arb (
        .clk    (clk),
        .reset  (reset),
        .req    (arb_req),
        .enable (arb_enable),
        .grant  (grant)
    );

    edge_bank_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .grant      (grant),
        .heads      (heads),
        .rs_ack     (rs_ack),
        .arb_enable (arb_enable),
        .rs_req     (rs_req),
        .rs_pkt     (rs_pkt),
        .rs_pop     (rs_pop)
    );

endmodule

`default_nettype wire

// File: logic/edge_lane_fifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "edge_settings.svh"

module edge_lane_fifo (
    input  logic                clk,
    input  logic                reset,
    input  edge_pkg::edge_pkt_t push_pkt,
    input  logic                pop,
    output edge_pkg::edge_pkt_t head,
    output logic                head_valid,
    output logic                full
);

    localparam int PTR_W = $clog2(`LANE_DEPTH);
    localparam int CNT_W = $clog2(`LANE_DEPTH + 1);

    edge_pkg::edge_pkt_t mem [`LANE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap at the last entry, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`LANE_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    // a full lane drops the push, PEs hold off on busy
    assign do_push    = push_pkt.valid && !full;
    assign do_pop     = pop && head_valid;
    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);
    assign full       = (count == CNT_W'(`LANE_DEPTH));

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_pkt;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/edge_pkg.sv
`default_nettype none
`include "edge_settings.svh"

package edge_pkg;

    // packet as driven by an edge PE
    typedef struct packed {
        logic                      valid;
        // start and end of stream
        logic                      sos;
        logic                      eos;
        logic [1:0][`FV_SIZE-1:0]  fv_data;
        logic                      done_aggr;
        // set for packets bound to output SRAM
        logic                      wb_en;
    } edge_pkt_t;

    // packet towards the reduction stage
    typedef struct packed {
        logic [`LANE_W-1:0]        lane;
        logic                      sos;
        logic                      eos;
        logic [1:0][`FV_SIZE-1:0]  fv_data;
        logic                      done_aggr;
    } rs_pkt_t;

    // write-back request to output SRAM
    typedef struct packed {
        logic                      sos;
        logic                      eos;
        logic [1:0][`FV_SIZE-1:0]  fv_data;
    } sram_req_t;

    // RS handshake controller
    typedef enum logic [1:0] {
        idle,
        grant_wait,
        req_high,
        ack_low
    } rs_state_e;

endpackage

`default_nettype wire

// File: logic/edge_settings.svh
`ifndef EDGE_SETTINGS_SVH
`define EDGE_SETTINGS_SVH

// one lane per edge PE, arbiter is built around 4
`define NUM_EDGE_PE 4

// bits to number a lane
`define LANE_W $clog2(`NUM_EDGE_PE)

// width of one feature value
`define FV_SIZE 16

// packets held per lane
`define LANE_DEPTH 4

`endif

// File: logic/rs_arbiter.sv
`timescale 1ns/100ps
`default_nettype none
`include "edge_settings.svh"

module rs_arbiter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`NUM_EDGE_PE-1:0] req,
    input  logic                    enable,
    output logic [`NUM_EDGE_PE-1:0] grant
);

    // lanes still eligible in this rotation
    logic [`NUM_EDGE_PE-1:0] rotate_ptr;
    logic [`NUM_EDGE_PE-1:0] mask_req;
    logic [`NUM_EDGE_PE-1:0] mask_grant;
    logic [`NUM_EDGE_PE-1:0] no_mask_grant;
    logic [`NUM_EDGE_PE-1:0] grant_comb;

    assign mask_req = req & rotate_ptr;

    // lowest set bit wins, x & -x
    assign mask_grant    = mask_req & (~mask_req + 1'b1);
    assign no_mask_grant = req & (~req + 1'b1);

    // fall back to the plain pick once the rotation runs out
    assign grant_comb = (|mask_req) ? mask_grant : no_mask_grant;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rotate_ptr <= '1;
            grant      <= '0;
        end else if (enable) begin
            grant <= grant_comb;
            // keep only lanes above the winner
            if (|grant_comb)
                rotate_ptr <= ~(grant_comb | (grant_comb - 1'b1));
        end else begin
            grant <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/sram_wb_port.sv
`timescale 1ns/100ps
`default_nettype none
`include "edge_settings.svh"

module sram_wb_port (
    input  logic                clk,
    input  logic                reset,
    input  edge_pkg::edge_pkt_t head,
    input  logic                head_valid,
    input  logic                sram_ack,
    output logic                sram_req,
    output edge_pkg::sram_req_t sram_pkt,
    output logic                pop
);

    typedef enum logic [1:0] {
        wb_idle,
        wb_req_high,
        wb_ack_low
    } wb_state_e;

    wb_state_e state;
    wb_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            wb_idle:     if (head_valid && head.wb_en) state_next = wb_req_high;
            wb_req_high: if (sram_ack) state_next = wb_ack_low;
            wb_ack_low:  if (!sram_ack) state_next = wb_idle;
            default:     state_next = wb_idle;
        endcase
    end

    assign sram_req = (state == wb_req_high);
    // packet is done once the SRAM has released ack
    assign pop = (state == wb_ack_low) && !sram_ack;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            state <= wb_idle;
        else
            state <= state_next;
    end

    // held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (state == wb_idle && head_valid && head.wb_en) begin
            sram_pkt.sos     <= head.sos;
            sram_pkt.eos     <= head.eos;
            sram_pkt.fv_data <= head.fv_data;
        end
    end

endmodule

`default_nettype wire
